// ==== mem_sys_params.svh ====
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// memory depth in 32-bit words
`define MEM_WORDS 4096

// word address width, log2 of the depth
`define ADDR_W 12

// cycles from request acceptance to response valid
`define MEM_LATENCY 2

`endif

// ==== mem_sys_pkg.sv ====
`include "mem_sys_params.svh"

package mem_sys_pkg;

    typedef logic [`ADDR_W-1:0] addr_t; // word address
    typedef logic [31:0]        word_t;

    // one memory access, 45 bits
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    // a write echoes the stored word here
    typedef struct packed {
        word_t rdata;
    } mem_rsp_t;

    // fetched instruction with its word address, 44 bits
    typedef struct packed {
        addr_t pc;
        word_t insn;
    } fetch_out_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we; // 1 = store
    } lsu_cmd_t;

endpackage

// ==== rv_slice.sv ====
`timescale 1ns/1ps

module rv_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic full;

    // free slot, or the held item leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid; // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import mem_sys_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // fetch port
    input  logic     f_req_valid,
    output logic     f_req_ready,
    input  mem_req_t f_req,
    output logic     f_rsp_valid,
    input  logic     f_rsp_ready,
    output mem_rsp_t f_rsp,
    // load/store port
    input  logic     l_req_valid,
    output logic     l_req_ready,
    input  mem_req_t l_req,
    output logic     l_rsp_valid,
    input  logic     l_rsp_ready,
    output mem_rsp_t l_rsp,
    // memory side
    output logic     m_req_valid,
    input  logic     m_req_ready,
    output mem_req_t m_req,
    input  logic     m_rsp_valid,
    output logic     m_rsp_ready,
    input  mem_rsp_t m_rsp
);

    logic last_l;      // lsu was served last
    logic outstanding; // one request in flight
    logic owner;       // 1 = lsu owns the response
    logic sel_l;

    // lsu wins when alone, or on a tie if fetch went last
    assign sel_l = l_req_valid && (!f_req_valid || !last_l);

    assign m_req_valid = !outstanding && (f_req_valid || l_req_valid);
    assign m_req       = sel_l ? l_req : f_req;
    assign f_req_ready = !outstanding && !sel_l && m_req_ready;
    assign l_req_ready = !outstanding && sel_l && m_req_ready;

    // response goes back to whoever issued it
    assign f_rsp_valid = m_rsp_valid && outstanding && !owner;
    assign l_rsp_valid = m_rsp_valid && outstanding && owner;
    assign f_rsp       = m_rsp;
    assign l_rsp       = m_rsp;
    assign m_rsp_ready = outstanding && (owner ? l_rsp_ready : f_rsp_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_l      <= 1'b1; // fetch gets the first tie
            outstanding <= 1'b0;
            owner       <= 1'b0;
        end else begin
            if (m_req_valid && m_req_ready) begin
                outstanding <= 1'b1;
                owner       <= sel_l;
                last_l      <= sel_l;
            end
            if (m_rsp_valid && m_rsp_ready) begin
                outstanding <= 1'b0;
            end
        end
    end

endmodule

// ==== lat_mem.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module lat_mem
    import mem_sys_pkg::*;
#(
    parameter int unsigned LATENCY = `MEM_LATENCY // at least 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);

    word_t mem [0:`MEM_WORDS-1];
    word_t rdata_q;
    logic  req_fire;
    logic  rsp_fire;

    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign rsp.rdata = rdata_q;

    // array is touched once at acceptance, the result then waits out the latency
    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
                rdata_q       <= req.wdata; // store echoes its word
            end else begin
                rdata_q <= mem[req.addr];
            end
        end
    end

    generate
        if (LATENCY == 1) begin : g_lat1
            assign req_ready = 1'b1; // next request may follow every cycle

            always_ff @(posedge clk) begin
                if (rst) begin
                    rsp_valid <= 1'b0;
                end else if (req_fire) begin
                    rsp_valid <= 1'b1;
                end else if (rsp_fire) begin
                    rsp_valid <= 1'b0;
                end
            end
        end else begin : g_latn
            localparam int CNT_W = $clog2(LATENCY);

            logic [CNT_W-1:0] cnt;
            logic             busy; // from acceptance until the response leaves

            assign req_ready = !busy;

            always_ff @(posedge clk) begin
                if (rst) begin
                    busy      <= 1'b0;
                    cnt       <= '0;
                    rsp_valid <= 1'b0;
                end else begin
                    if (req_fire) begin
                        busy <= 1'b1;
                        cnt  <= CNT_W'(LATENCY - 2);
                    end else if (busy && !rsp_valid) begin
                        if (cnt != '0) begin
                            cnt <= cnt - 1'b1;
                        end else begin
                            rsp_valid <= 1'b1; // latency window over
                        end
                    end
                    if (rsp_fire) begin
                        rsp_valid <= 1'b0;
                        busy      <= 1'b0;
                    end
                end
            end
        end
    endgenerate

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import mem_sys_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  addr_t      base,
    input  addr_t      count,
    output logic       done,
    output logic       req_valid,
    input  logic       req_ready,
    output mem_req_t   req,
    input  logic       rsp_valid,
    output logic       rsp_ready,
    input  mem_rsp_t   rsp,
    output logic       insn_valid,
    input  logic       insn_ready,
    output fetch_out_t insn
);

    logic       active;
    logic       pend;       // one fetch in flight
    addr_t      next_addr;
    addr_t      issue_left; // requests still to send
    addr_t      pc_q;       // address of the fetch in flight
    logic       s_in_ready;
    logic       req_fire;
    logic       rsp_fire;
    fetch_out_t s_in;

    assign req_valid = active && !pend && (issue_left != '0);
    assign req_fire  = req_valid && req_ready;
    assign req.addr  = next_addr;
    assign req.wdata = '0;
    assign req.we    = 1'b0;

    // full slice stalls the memory response
    assign rsp_ready = s_in_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign s_in.pc   = pc_q;
    assign s_in.insn = rsp.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            pend   <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !active) begin
                active <= (count != '0);
                done   <= (count == '0); // empty run ends at once
            end
            if (req_fire) begin
                pend <= 1'b1;
            end
            if (rsp_fire) begin
                pend <= 1'b0;
                if (issue_left == '0) begin // last word just entered the slice
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !active) begin
            next_addr  <= base;
            issue_left <= count;
        end else if (req_fire) begin
            next_addr  <= next_addr + 1'b1;
            issue_left <= issue_left - 1'b1;
            pc_q       <= next_addr;
        end
    end

    rv_slice #(
        .payload_t (fetch_out_t)
    ) u_out (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rsp_valid),
        .in_ready  (s_in_ready),
        .in_data   (s_in),
        .out_valid (insn_valid),
        .out_ready (insn_ready),
        .out_data  (insn)
    );

endmodule

// ==== lsu.sv ====
`timescale 1ns/1ps

module lsu
    import mem_sys_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  lsu_cmd_t cmd,
    output logic     req_valid,
    input  logic     req_ready,
    output mem_req_t req,
    input  logic     rsp_valid,
    output logic     rsp_ready,
    input  mem_rsp_t rsp,
    output logic     ld_valid,
    input  logic     ld_ready,
    output word_t    ld_data
);

    logic pend;    // command issued, response not back yet
    logic is_load;
    logic s_in_ready;

    // command passes straight through as the request
    assign req_valid = cmd_valid && !pend;
    assign cmd_ready = !pend && req_ready;
    assign req.addr  = cmd.addr;
    assign req.wdata = cmd.wdata;
    assign req.we    = cmd.we;

    // store echoes are taken and dropped
    assign rsp_ready = is_load ? s_in_ready : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend    <= 1'b0;
            is_load <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                pend    <= 1'b1;
                is_load <= !cmd.we;
            end
            if (rsp_valid && rsp_ready) begin
                pend <= 1'b0;
            end
        end
    end

    rv_slice #(
        .payload_t (word_t)
    ) u_ld (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rsp_valid && is_load),
        .in_ready  (s_in_ready),
        .in_data   (rsp.rdata),
        .out_valid (ld_valid),
        .out_ready (ld_ready),
        .out_data  (ld_data)
    );

endmodule

// ==== mem_sys_top.sv ====
`timescale 1ns/1ps

module mem_sys_top
    import mem_sys_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  addr_t      base,
    input  addr_t      count,
    output logic       done,
    output logic       insn_valid,
    input  logic       insn_ready,
    output fetch_out_t insn,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  lsu_cmd_t   cmd,
    output logic       ld_valid,
    input  logic       ld_ready,
    output word_t      ld_data
);

    logic     f_req_valid, f_req_ready, f_rsp_valid, f_rsp_ready;
    logic     l_req_valid, l_req_ready, l_rsp_valid, l_rsp_ready;
    logic     m_req_valid, m_req_ready, m_rsp_valid, m_rsp_ready;
    mem_req_t f_req, l_req, m_req;
    mem_rsp_t f_rsp, l_rsp, m_rsp;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .base       (base),
        .count      (count),
        .done       (done),
        .req_valid  (f_req_valid),
        .req_ready  (f_req_ready),
        .req        (f_req),
        .rsp_valid  (f_rsp_valid),
        .rsp_ready  (f_rsp_ready),
        .rsp        (f_rsp),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .insn       (insn)
    );

    lsu u_lsu (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .req_valid (l_req_valid),
        .req_ready (l_req_ready),
        .req       (l_req),
        .rsp_valid (l_rsp_valid),
        .rsp_ready (l_rsp_ready),
        .rsp       (l_rsp),
        .ld_valid  (ld_valid),
        .ld_ready  (ld_ready),
        .ld_data   (ld_data)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .f_req_valid (f_req_valid),
        .f_req_ready (f_req_ready),
        .f_req       (f_req),
        .f_rsp_valid (f_rsp_valid),
        .f_rsp_ready (f_rsp_ready),
        .f_rsp       (f_rsp),
        .l_req_valid (l_req_valid),
        .l_req_ready (l_req_ready),
        .l_req       (l_req),
        .l_rsp_valid (l_rsp_valid),
        .l_rsp_ready (l_rsp_ready),
        .l_rsp       (l_rsp),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req       (m_req),
        .m_rsp_valid (m_rsp_valid),
        .m_rsp_ready (m_rsp_ready),
        .m_rsp       (m_rsp)
    );

    lat_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .req_valid (m_req_valid),
        .req_ready (m_req_ready),
        .req       (m_req),
        .rsp_valid (m_rsp_valid),
        .rsp_ready (m_rsp_ready),
        .rsp       (m_rsp)
    );

endmodule

// ==== mem_sys_props.sv ====
`timescale 1ns/1ps

module mem_sys_props
    import mem_sys_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_valid,
    input logic     req_ready,
    input mem_req_t req,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input mem_rsp_t rsp
);

    logic busy; // accepted request whose response has not transferred

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                busy <= 1'b0;
            end
            if (req_valid && req_ready) begin
                busy <= 1'b1;
            end
        end
    end

    a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> busy)
        else $error("response valid with no request outstanding");

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_ready) |-> (!busy || (rsp_valid && rsp_ready)))
        else $error("second request accepted while one is outstanding");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("request dropped or changed before transfer");

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("response dropped or changed before transfer");

endmodule

// ==== tb_mem_sys.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module tb_mem_sys
    import mem_sys_pkg::*;
();

    localparam int MAX_CYCLES = 20000; // tests need about 2000
    localparam int WAIT_LIMIT = 4000;

    logic       clk;
    logic       rst;
    logic       start;
    addr_t      base;
    addr_t      count;
    logic       done;
    logic       insn_valid;
    logic       insn_ready = 1'b1;
    fetch_out_t insn;
    logic       cmd_valid;
    logic       cmd_ready;
    lsu_cmd_t   cmd;
    logic       ld_valid;
    logic       ld_ready = 1'b1;
    word_t      ld_data;

    word_t       shadow [addr_t]; // last word written per address
    fetch_out_t  insn_got[$];
    fetch_out_t  exp_insn[$];
    word_t       ld_got[$];
    word_t       exp_ld[$];
    logic [31:0] seed = 32'd84105;
    logic [31:0] ready_rnd = 32'd84105; // separate stream for back-pressure
    logic        stall_mode = 1'b0;
    int          cycles = 0;
    int          done_cnt = 0;
    int          err_cnt = 0;
    int          mon_errs = 0;
    int          err_base;
    int          insn_base;
    int          ld_base;
    int          done_base;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        insn_hold = 1'b0;
    logic        ld_hold = 1'b0;
    fetch_out_t  insn_prev;
    word_t       ld_prev;

    mem_sys_top dut (.*);

    // each arbiter port on its own, so a misrouted response shows up
    bind mem_arbiter mem_sys_props u_fetch_props (
        .clk (clk), .rst (rst),
        .req_valid (f_req_valid), .req_ready (f_req_ready), .req (f_req),
        .rsp_valid (f_rsp_valid), .rsp_ready (f_rsp_ready), .rsp (f_rsp)
    );

    bind mem_arbiter mem_sys_props u_lsu_props (
        .clk (clk), .rst (rst),
        .req_valid (l_req_valid), .req_ready (l_req_ready), .req (l_req),
        .rsp_valid (l_rsp_valid), .rsp_ready (l_rsp_ready), .rsp (l_rsp)
    );

    bind lat_mem mem_sys_props u_mem_props (
        .clk (clk), .rst (rst),
        .req_valid (req_valid), .req_ready (req_ready), .req (req),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ready goes low for random stretches while stalling
    always @(posedge clk) begin
        if (!stall_mode) begin
            insn_ready <= 1'b1;
            ld_ready   <= 1'b1;
        end else begin
            ready_rnd = lcg_step(ready_rnd);
            if (ready_rnd[27:26] == 2'b00) begin
                insn_ready <= ready_rnd[20];
            end
            if (ready_rnd[25:24] == 2'b00) begin
                ld_ready <= ready_rnd[21];
            end
        end
    end

    // outputs sampled mid-cycle, a handshake seen here transfers on the next edge
    always @(negedge clk) begin
        if (!rst) begin
            if (insn_hold && (!insn_valid || insn != insn_prev)) begin
                $display("FAIL %0t: insn output dropped or changed while stalled", $time);
                mon_errs++;
            end
            if (ld_hold && (!ld_valid || ld_data != ld_prev)) begin
                $display("FAIL %0t: load output dropped or changed while stalled", $time);
                mon_errs++;
            end
            if (insn_valid && insn_ready) begin
                insn_got.push_back(insn);
            end
            if (ld_valid && ld_ready) begin
                ld_got.push_back(ld_data);
            end
            if (done) begin
                done_cnt++;
            end
            insn_hold = insn_valid && !insn_ready;
            insn_prev = insn;
            ld_hold   = ld_valid && !ld_ready;
            ld_prev   = ld_data;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_step(seed);
        r    = seed;
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic send_cmd(input addr_t a, input word_t d, input logic we);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= '{addr: a, wdata: d, we: we};
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk); // transfer edge
        cmd_valid <= 1'b0;
    endtask

    task automatic store_word(input addr_t a, input word_t d);
        shadow[a] = d;
        send_cmd(a, d, 1'b1);
    endtask

    task automatic load_word(input addr_t a);
        exp_ld.push_back(shadow[a]);
        send_cmd(a, '0, 1'b0);
    endtask

    task automatic run_fetch(input addr_t b, input int n);
        fetch_out_t e;
        for (int i = 0; i < n; i++) begin
            e.pc   = addr_t'(b + i);
            e.insn = shadow[e.pc];
            exp_insn.push_back(e);
        end
        @(posedge clk);
        start <= 1'b1;
        base  <= b;
        count <= addr_t'(n);
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic begin_test();
        exp_insn.delete();
        exp_ld.delete();
        insn_base = insn_got.size();
        ld_base   = ld_got.size();
        done_base = done_cnt;
        err_base  = err_cnt + mon_errs;
        tests_run++;
    endtask

    task automatic end_test(input string name, input int n_done);
        int k;
        int n_insn;
        int n_ld;
        k = 0;
        while ((insn_got.size() - insn_base < exp_insn.size()
                || ld_got.size() - ld_base < exp_ld.size()
                || done_cnt - done_base < n_done) && k < WAIT_LIMIT) begin
            @(negedge clk);
            k++;
        end
        if (k >= WAIT_LIMIT) begin
            $display("%s: expected outputs did not arrive within %0d cycles", name, k);
            err_cnt++;
        end
        repeat (20) @(negedge clk); // room for extra items to show up
        n_insn = insn_got.size() - insn_base;
        n_ld   = ld_got.size() - ld_base;
        if (n_insn != exp_insn.size()) begin
            report_fail($sformatf("%s: got %0d insns, expected %0d", name, n_insn,
                                  exp_insn.size()));
        end
        if (n_ld != exp_ld.size()) begin
            report_fail($sformatf("%s: got %0d loads, expected %0d", name, n_ld, exp_ld.size()));
        end
        if (done_cnt - done_base != n_done) begin
            report_fail($sformatf("%s: done pulsed %0d times, expected %0d", name,
                                  done_cnt - done_base, n_done));
        end
        for (int i = 0; i < n_insn && i < exp_insn.size(); i++) begin
            if (insn_got[insn_base + i] != exp_insn[i]) begin
                report_fail($sformatf("%s: insn %0d pc %h data %h, expected pc %h data %h",
                    name, i, insn_got[insn_base + i].pc, insn_got[insn_base + i].insn,
                    exp_insn[i].pc, exp_insn[i].insn));
            end
        end
        for (int i = 0; i < n_ld && i < exp_ld.size(); i++) begin
            if (ld_got[ld_base + i] != exp_ld[i]) begin
                report_fail($sformatf("%s: load %0d data %h, expected %h", name, i,
                                      ld_got[ld_base + i], exp_ld[i]));
            end
        end
        if (err_cnt + mon_errs == err_base) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_cnt + mon_errs - err_base);
        end
    endtask

    task automatic test_store_load();
        logic [31:0] r;
        addr_t       a;
        begin_test();
        next_rand(r);
        a = addr_t'((r >> 8) % `MEM_WORDS);
        next_rand(r);
        store_word(a, r);
        load_word(a);
        end_test("store then load", 0);
    endtask

    task automatic test_fetch_run();
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < 16; i++) begin
            next_rand(r);
            store_word(addr_t'(12'h100 + i), r);
        end
        run_fetch(12'h100, 16);
        end_test("fetch run", 1);
    endtask

    // fetch and loads compete for the arbiter
    task automatic test_fetch_with_loads(input string name, input addr_t fb, input addr_t lb,
                                         input logic stall);
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < 24; i++) begin
            next_rand(r);
            store_word(addr_t'(fb + i), r);
        end
        for (int i = 0; i < 12; i++) begin
            next_rand(r);
            store_word(addr_t'(lb + i), r);
        end
        stall_mode = stall;
        fork
            run_fetch(fb, 24);
            for (int i = 0; i < 12; i++) begin
                load_word(addr_t'(lb + i));
            end
        join
        end_test(name, 1);
        stall_mode = 1'b0;
    endtask

    task automatic test_sweep();
        logic [31:0] r;
        addr_t       a;
        addr_t       addrs[$];
        begin_test();
        for (int i = 0; i < 64; i++) begin
            next_rand(r);
            a = addr_t'(12'h800 + (r >> 16) % 32); // narrow window, addresses repeat
            addrs.push_back(a);
            next_rand(r);
            store_word(a, r);
        end
        foreach (addrs[i]) begin
            load_word(addrs[i]);
        end
        end_test("store/load sweep", 0);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        base      = '0;
        count     = '0;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_store_load();
        test_fetch_run();
        test_fetch_with_loads("fetch with loads", 12'h200, 12'h300, 1'b0);
        test_fetch_with_loads("back-pressure", 12'h400, 12'h500, 1'b1);
        test_sweep();
        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed,
                 err_cnt + mon_errs);
        if (tests_failed == 0 && err_cnt + mon_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
mem_sys_pkg.sv
rv_slice.sv
mem_arbiter.sv
lat_mem.sv
fetch_unit.sv
lsu.sv
mem_sys_top.sv
mem_sys_props.sv
tb_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_mem_sys -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -qx "test passed" sim.log; then
    echo "simulation: PASS"
    exit 0
else
    echo "simulation: FAIL"
    exit 1
fi
